/* common/mem_pkg.sv */
// ==========================================================================
// Shared types and preload pattern for the memory-side interior
// ==========================================================================
`default_nettype none

package mem_pkg;

	localparam int LINE_BYTES = 8;                  // Bytes per line
	localparam int N_LINES    = 64;                 // Lines in the store

	typedef logic [LINE_BYTES*8-1:0] line_t;        // One memory line
	typedef logic [LINE_BYTES-1:0]   wbe_t;         // Byte write enables
	typedef logic [5:0]              line_addr_t;   // Line index
	typedef logic [7:0]              led_t;         // One LED byte

	typedef enum logic {
		MEM_OPC_READ  = 1'b0,
		MEM_OPC_WRITE = 1'b1
	} mem_opc_e;

	localparam led_t LED_RESET = 8'haa;             // Alternating LEDs out of reset

	// Preload content of one line.
	// Byte j holds (a + 37*j) mod 256, so byte 0 is the line index itself
	function automatic line_t pattern_line(input line_addr_t a);
		line_t l;
		l = '0;
		for (int j = 0; j < LINE_BYTES; j++) begin
			l[j*8 +: 8] = 8'(int'(a) + 37 * j);     // Wraps mod 256
		end
		return l;
	endfunction

endpackage

`default_nettype wire

/* hw/mem_preload.sv */
// ==========================================================================
// Preload engine, writes the pattern into every store line after reset
// and then holds done high until the next reset
// ==========================================================================
`timescale 1ns/1ns
`default_nettype none

module mem_preload (
	input  wire                 clkrst_mem_clk,
	input  wire                 rst_n,
	output logic                valid,
	output mem_pkg::mem_opc_e   opc,
	output mem_pkg::line_addr_t addr,
	output mem_pkg::line_t      wdata,
	output mem_pkg::wbe_t       wbe,
	input  wire                 stall,
	output logic                done
);

	typedef enum logic [1:0] {
		PRE_IDLE,
		PRE_FILL,
		PRE_DONE
	} pre_state_e;

	localparam mem_pkg::line_addr_t LAST_LINE = mem_pkg::line_addr_t'(mem_pkg::N_LINES - 1);

	pre_state_e          state_q;
	mem_pkg::line_addr_t cnt_q;                     // Line being written
	logic                accept;

	assign accept = valid && !stall;                // Write taken by arbiter

	always_ff @(posedge clkrst_mem_clk) begin
		if (!rst_n) begin
			state_q <= PRE_IDLE;
			cnt_q   <= '0;
		end else begin
			case (state_q)
				PRE_IDLE: state_q <= PRE_FILL;      // First cycle out of reset
				PRE_FILL: begin
					if (accept) begin
						cnt_q <= cnt_q + 1'b1;      // Next line
						if (cnt_q == LAST_LINE)
							state_q <= PRE_DONE;    // Last write taken
					end
				end
				PRE_DONE: state_q <= PRE_DONE;      // Quiet until reset
				default:  state_q <= PRE_IDLE;
			endcase
		end
	end

	// Request fields come straight from the counter, so they hold under stall
	assign valid = (state_q == PRE_FILL);
	assign opc   = mem_pkg::MEM_OPC_WRITE;
	assign addr  = cnt_q;
	assign wdata = mem_pkg::pattern_line(cnt_q);
	assign wbe   = '1;                              // Full line write
	assign done  = (state_q == PRE_DONE);

endmodule

`default_nettype wire

/* hw/led_poller.sv */
// ==========================================================================
// LED poller, reads its window of lines at a fixed interval and shows
// the low byte of each returned line on its LEDs
// ==========================================================================
`timescale 1ns/1ns
`default_nettype none

module led_poller #(
	parameter int POLLER_IDX    = 0,
	parameter int POLL_INTERVAL = 16,
	parameter int WINDOW_LINES  = 16
) (
	input  wire                 clkrst_mem_clk,
	input  wire                 rst_n,
	input  wire                 pre_done,
	output logic                valid,
	output mem_pkg::line_addr_t addr,
	input  wire                 stall,
	input  wire                 rvalid,
	input  mem_pkg::line_t      rdata,
	output mem_pkg::led_t       leds
);

	localparam int CW = $clog2(POLL_INTERVAL + 1);  // Interval counter width
	localparam mem_pkg::line_addr_t BASE = mem_pkg::line_addr_t'(POLLER_IDX * WINDOW_LINES);
	localparam mem_pkg::line_addr_t LAST_OFS = mem_pkg::line_addr_t'(WINDOW_LINES - 1);

	logic [CW-1:0]       cnt_q;                     // Cycles since last return
	mem_pkg::line_addr_t ofs_q;                     // Offset within window
	logic                busy_q;                    // Read accepted, data pending
	logic                counting;
	logic                accept;

	assign counting = pre_done && !valid && !busy_q;
	assign accept   = valid && !stall;

	always_ff @(posedge clkrst_mem_clk) begin
		if (!rst_n) begin
			cnt_q  <= '0;
			ofs_q  <= '0;
			valid  <= 1'b0;
			busy_q <= 1'b0;
			leds   <= mem_pkg::LED_RESET;
		end else begin
			if (counting) begin
				if (cnt_q == CW'(POLL_INTERVAL - 1)) begin
					cnt_q <= '0;
					valid <= 1'b1;                  // Interval expired, ask
				end else begin
					cnt_q <= cnt_q + 1'b1;
				end
			end

			if (accept) begin
				valid  <= 1'b0;
				busy_q <= 1'b1;
				// Wrap inside the window
				ofs_q  <= (ofs_q == LAST_OFS) ? '0 : ofs_q + 1'b1;
			end

			if (rvalid) begin
				busy_q <= 1'b0;                     // Free to count again
				leds   <= rdata[7:0];               // Low byte to LEDs
			end
		end
	end

	assign addr = BASE + ofs_q;                     // Stable while valid is up

endmodule

`default_nettype wire

/* mem/mem_arb.sv */
// ==========================================================================
// Store arbiter, preload engine first and pollers in round robin,
// with read returns steered back to the poller that asked
// ==========================================================================
`timescale 1ns/1ns
`default_nettype none

module mem_arb #(
	parameter int N_POLLERS = 4
) (
	input  wire                                 clkrst_mem_clk,
	input  wire                                 rst_n,

	input  wire                                 pre_valid,
	input  mem_pkg::mem_opc_e                   pre_opc,
	input  mem_pkg::line_addr_t                 pre_addr,
	input  mem_pkg::line_t                      pre_wdata,
	input  mem_pkg::wbe_t                       pre_wbe,
	output logic                                pre_stall,

	input  wire [N_POLLERS-1:0]                 pol_valid,
	input  mem_pkg::line_addr_t [N_POLLERS-1:0] pol_addr,
	output logic [N_POLLERS-1:0]                pol_stall,
	output logic [N_POLLERS-1:0]                pol_rvalid,
	output mem_pkg::line_t                      rdata,

	output logic                                st_valid,
	output mem_pkg::mem_opc_e                   st_opc,
	output mem_pkg::line_addr_t                 st_addr,
	output mem_pkg::line_t                      st_wdata,
	output mem_pkg::wbe_t                       st_wbe,
	input  wire                                 st_rvalid,
	input  mem_pkg::line_t                      st_rdata
);

	localparam int PW = (N_POLLERS > 1) ? $clog2(N_POLLERS) : 1;

	logic [PW-1:0]        rr_ptr_q;                 // Last poller granted
	logic [PW-1:0]        gnt_idx;                  // Round-robin winner
	logic                 pol_hit;                  // Some poller is asking
	logic                 pol_take;                 // Poller actually wins
	logic [N_POLLERS-1:0] pol_gnt;
	logic [N_POLLERS-1:0] tag_q;                    // Reader owed the next rvalid

	// Search starts one past the last grant
	always_comb begin
		int idx;
		pol_hit = 1'b0;
		gnt_idx = rr_ptr_q;
		for (int i = 1; i <= N_POLLERS; i++) begin
			idx = (int'(rr_ptr_q) + i) % N_POLLERS;
			if (!pol_hit && pol_valid[idx]) begin
				pol_hit = 1'b1;
				gnt_idx = PW'(idx);
			end
		end
	end

	assign pol_take = pol_hit && !pre_valid;        // Preload has priority

	always_comb begin
		pol_gnt = '0;
		if (pol_take)
			pol_gnt[gnt_idx] = 1'b1;
	end

	assign pre_stall = 1'b0;                        // Top priority, never held
	assign pol_stall = pol_valid & ~pol_gnt;        // Losers hold their request

	// Request mux toward the store
	assign st_valid = pre_valid || pol_hit;
	assign st_opc   = pre_valid ? pre_opc   : mem_pkg::MEM_OPC_READ;
	assign st_addr  = pre_valid ? pre_addr  : pol_addr[gnt_idx];
	assign st_wdata = pre_valid ? pre_wdata : '0;   // Pollers never write
	assign st_wbe   = pre_valid ? pre_wbe   : '0;

	always_ff @(posedge clkrst_mem_clk) begin
		if (!rst_n) begin
			rr_ptr_q <= '0;
			tag_q    <= '0;
		end else begin
			if (pol_take)
				rr_ptr_q <= gnt_idx;                // Advance fairness pointer
			tag_q <= pol_gnt;                       // Store answers next cycle
		end
	end

	// Return path
	assign pol_rvalid = st_rvalid ? tag_q : '0;
	assign rdata      = st_rdata;                   // Broadcast, rvalid picks owner

endmodule

`default_nettype wire

/* mem/mem_store.sv */
// ==========================================================================
// Line store with byte-enabled writes and single-cycle read return
// ==========================================================================
`timescale 1ns/1ns
`default_nettype none

module mem_store (
	input  wire                 clkrst_mem_clk,
	input  wire                 rst_n,
	input  wire                 st_valid,
	input  mem_pkg::mem_opc_e   st_opc,
	input  mem_pkg::line_addr_t st_addr,
	input  mem_pkg::line_t      st_wdata,
	input  mem_pkg::wbe_t       st_wbe,
	output logic                st_rvalid,
	output mem_pkg::line_t      st_rdata
);

	mem_pkg::line_t mem_q [mem_pkg::N_LINES];       // Line array
	logic           wr_en;
	logic           rd_en;

	assign wr_en = st_valid && (st_opc == mem_pkg::MEM_OPC_WRITE);
	assign rd_en = st_valid && (st_opc == mem_pkg::MEM_OPC_READ);

	// Byte lanes
	always_ff @(posedge clkrst_mem_clk) begin
		if (wr_en) begin
			for (int b = 0; b < mem_pkg::LINE_BYTES; b++) begin
				if (st_wbe[b])
					mem_q[st_addr][b*8 +: 8] <= st_wdata[b*8 +: 8];
			end
		end
	end

	// Read data register, no reset on the payload
	always_ff @(posedge clkrst_mem_clk) begin
		if (rd_en)
			st_rdata <= mem_q[st_addr];
	end

	always_ff @(posedge clkrst_mem_clk) begin
		if (!rst_n)
			st_rvalid <= 1'b0;
		else
			st_rvalid <= rd_en;                     // One cycle after accept
	end

endmodule

`default_nettype wire

/* hw/mem_int.sv */
// ==========================================================================
// Memory-side interior, preload engine, LED pollers, arbiter and store
// ==========================================================================
`timescale 1ns/1ns
`default_nettype none

module mem_int #(
	parameter int N_POLLERS     = 4,
	parameter int POLL_INTERVAL = 16,
	parameter int WINDOW_LINES  = 16
) (
	input  wire                            clkrst_mem_clk,
	input  wire                            rst_n,
	output mem_pkg::led_t [N_POLLERS-1:0]  leds,
	output logic                           pre_done
);

	// Preload client
	logic                pre_valid;
	mem_pkg::mem_opc_e   pre_opc;
	mem_pkg::line_addr_t pre_addr;
	mem_pkg::line_t      pre_wdata;
	mem_pkg::wbe_t       pre_wbe;
	logic                pre_stall;

	// Poller clients, one lane each
	logic [N_POLLERS-1:0]                pol_valid;
	mem_pkg::line_addr_t [N_POLLERS-1:0] pol_addr;
	logic [N_POLLERS-1:0]                pol_stall;
	logic [N_POLLERS-1:0]                pol_rvalid;
	mem_pkg::line_t                      pol_rdata;

	// Arbiter to store
	logic                st_valid;
	mem_pkg::mem_opc_e   st_opc;
	mem_pkg::line_addr_t st_addr;
	mem_pkg::line_t      st_wdata;
	mem_pkg::wbe_t       st_wbe;
	logic                st_rvalid;
	mem_pkg::line_t      st_rdata;

	mem_preload u_pre (
		.clkrst_mem_clk (clkrst_mem_clk),
		.rst_n          (rst_n),
		.valid          (pre_valid),
		.opc            (pre_opc),
		.addr           (pre_addr),
		.wdata          (pre_wdata),
		.wbe            (pre_wbe),
		.stall          (pre_stall),
		.done           (pre_done)
	);

	for (genvar k = 0; k < N_POLLERS; k++) begin : g_poller
		led_poller #(
			.POLLER_IDX    (k),
			.POLL_INTERVAL (POLL_INTERVAL),
			.WINDOW_LINES  (WINDOW_LINES)
		) u_poller (
			.clkrst_mem_clk (clkrst_mem_clk),
			.rst_n          (rst_n),
			.pre_done       (pre_done),
			.valid          (pol_valid[k]),
			.addr           (pol_addr[k]),
			.stall          (pol_stall[k]),
			.rvalid         (pol_rvalid[k]),
			.rdata          (pol_rdata),
			.leds           (leds[k])
		);
	end

	mem_arb #(
		.N_POLLERS (N_POLLERS)
	) u_arb (
		.clkrst_mem_clk (clkrst_mem_clk),
		.rst_n          (rst_n),
		.pre_valid      (pre_valid),
		.pre_opc        (pre_opc),
		.pre_addr       (pre_addr),
		.pre_wdata      (pre_wdata),
		.pre_wbe        (pre_wbe),
		.pre_stall      (pre_stall),
		.pol_valid      (pol_valid),
		.pol_addr       (pol_addr),
		.pol_stall      (pol_stall),
		.pol_rvalid     (pol_rvalid),
		.rdata          (pol_rdata),
		.st_valid       (st_valid),
		.st_opc         (st_opc),
		.st_addr        (st_addr),
		.st_wdata       (st_wdata),
		.st_wbe         (st_wbe),
		.st_rvalid      (st_rvalid),
		.st_rdata       (st_rdata)
	);

	mem_store u_store (
		.clkrst_mem_clk (clkrst_mem_clk),
		.rst_n          (rst_n),
		.st_valid       (st_valid),
		.st_opc         (st_opc),
		.st_addr        (st_addr),
		.st_wdata       (st_wdata),
		.st_wbe         (st_wbe),
		.st_rvalid      (st_rvalid),
		.st_rdata       (st_rdata)
	);

endmodule

`default_nettype wire

/* tb/mem_int_tb.sv */
// ==========================================================================
// Testbench for the memory-side interior that checks preload, LED sequences,
// round-robin progress and a random second reset
// ==========================================================================
`timescale 1ns/1ns
`default_nettype none

module mem_int_tb;

	localparam int N_POLLERS     = 4;
	localparam int POLL_INTERVAL = 16;
	localparam int WINDOW_LINES  = 16;

	localparam int RESET_CYCLES  = 3;
	localparam int PRELOAD_LINES = 64;                  // One accepted write per line
	localparam int PRE_BOUND     = PRELOAD_LINES + 8;   // Preload plus a few cycles
	localparam int RESET2_MIN    = 200;                 // Earliest second reset after done
	localparam int RESET2_BITS   = 9;                   // Random part of up to 511 cycles
	localparam int WALK_CYCLES   = 2 * WINDOW_LINES * N_POLLERS * POLL_INTERVAL;
	localparam int TIMEOUT_CYCLES = 2 * (RESET_CYCLES + PRE_BOUND) + RESET2_MIN
		+ (1 << RESET2_BITS) + WALK_CYCLES + 500;

	localparam logic [31:0] LFSR_SEED = 32'he755_0c89;
	localparam logic [31:0] LFSR_TAPS = 32'h8020_0003; // x^32 + x^22 + x^2 + x + 1
	localparam logic [7:0]  LED_IDLE  = 8'haa;         // LEDs out of reset

	logic                          clkrst_mem_clk = 1'b0;
	logic                          rst_n;
	mem_pkg::led_t [N_POLLERS-1:0] leds;
	logic                          pre_done;

	logic [31:0] lfsr_state;
	logic [7:0]  prev_leds [N_POLLERS];                 // Last LED byte seen
	int          read_cnt  [N_POLLERS];                 // Reads seen since reset
	int          err_cnt   = 0;
	int          check_cnt = 0;
	int          since_rel = 0;                         // Cycles since reset release
	int          cycle_cnt = 0;
	logic        in_reset  = 1'b1;
	logic        done_seen = 1'b0;

	mem_int #(
		.N_POLLERS     (N_POLLERS),
		.POLL_INTERVAL (POLL_INTERVAL),
		.WINDOW_LINES  (WINDOW_LINES)
	) mem_int_i (
		.clkrst_mem_clk (clkrst_mem_clk),
		.rst_n          (rst_n),
		.leds           (leds),
		.pre_done       (pre_done)
	);

	always #50 clkrst_mem_clk = ~clkrst_mem_clk;        // 100 ns period

	// LED of poller k after its n-th read equals the window line index
	function automatic logic [7:0] expected_led(input int k, input int n);
		int line_idx;
		line_idx = k * WINDOW_LINES + (n % WINDOW_LINES);
		return 8'(line_idx);
	endfunction

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ LFSR_TAPS;
		else
			return s >> 1;
	endfunction

	function automatic logic all_walked();
		logic ok;
		ok = 1'b1;
		for (int k = 0; k < N_POLLERS; k++) begin
			if (read_cnt[k] < 2 * WINDOW_LINES)
				ok = 1'b0;                              // Still short of two walks
		end
		return ok;
	endfunction

	task automatic take_bits(input int n, output int val);
		val = 0;
		for (int i = 0; i < n; i++) begin
			val = (val << 1) | int'(lfsr_state[0]);    // One LFSR step per bit
			lfsr_state = lfsr_step(lfsr_state);
		end
	endtask

	task automatic hold_reset();
		rst_n <= 1'b0;
		repeat (RESET_CYCLES) @(posedge clkrst_mem_clk);
		rst_n <= 1'b1;                                  // Seen by the DUT next edge
	endtask

	task automatic wait_preload();
		do
			@(negedge clkrst_mem_clk);
		while (!pre_done);
		@(posedge clkrst_mem_clk);
	endtask

	task automatic finish_run();
		$display("checks: %0d  errors: %0d", check_cnt, err_cnt);
		if (err_cnt == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	endtask

	// Stimulus
	initial begin
		int gap;
		lfsr_state = LFSR_SEED;
		hold_reset();
		wait_preload();
		take_bits(RESET2_BITS, gap);
		$display("Second reset in %0d cycles", RESET2_MIN + gap);
		repeat (RESET2_MIN + gap) @(posedge clkrst_mem_clk);
		hold_reset();
		wait_preload();
		while (!all_walked())
			@(posedge clkrst_mem_clk);                  // Two walks per poller
		finish_run();
	end

	// Compare process samples on the falling edge
	always @(negedge clkrst_mem_clk) begin
		if (!rst_n) begin
			in_reset = 1'b1;
			for (int k = 0; k < N_POLLERS; k++)
				read_cnt[k] = 0;                        // Sequences start over
		end else if (in_reset) begin
			in_reset  = 1'b0;                           // First sample after release
			since_rel = 0;
			done_seen = 1'b0;
			check_cnt++;
			assert (!pre_done) else begin
				err_cnt++;
				$display("ERR %0t: pre_done high right after reset", $time);
			end
			for (int k = 0; k < N_POLLERS; k++) begin
				check_cnt++;
				assert (leds[k] == LED_IDLE) else begin
					err_cnt++;
					$display("ERR %0t: poller %0d LED %02h after reset, expected %02h",
						$time, k, leds[k], LED_IDLE);
				end
				prev_leds[k] = leds[k];
			end
		end else begin
			since_rel++;
			if (done_seen) begin
				assert (pre_done) else begin
					err_cnt++;
					$display("ERR %0t: pre_done fell without a reset", $time);
				end
			end
			if (pre_done)
				done_seen = 1'b1;
			if (since_rel == PRE_BOUND) begin
				check_cnt++;
				assert (done_seen) else begin
					err_cnt++;
					$display("ERR %0t: pre_done not raised within %0d cycles",
						$time, PRE_BOUND);
				end
			end
			for (int k = 0; k < N_POLLERS; k++) begin
				if (leds[k] != prev_leds[k]) begin
					check_cnt++;
					assert (pre_done) else begin
						err_cnt++;
						$display("ERR %0t: poller %0d LED changed before preload done",
							$time, k);
					end
					assert (leds[k] == expected_led(k, read_cnt[k])) else begin
						err_cnt++;
						$display("ERR %0t: poller %0d read %0d LED %02h, expected %02h",
							$time, k, read_cnt[k], leds[k], expected_led(k, read_cnt[k]));
					end
					read_cnt[k]++;
					prev_leds[k] = leds[k];
				end
			end
		end
	end

	// Timeout
	always @(posedge clkrst_mem_clk) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles, the pollers did not finish two walks",
				cycle_cnt);
			$display("checks: %0d  errors: %0d", check_cnt, err_cnt);
			$display("** FAIL **");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* sim.f */
common/mem_pkg.sv
hw/mem_preload.sv
hw/led_poller.sv
mem/mem_arb.sv
mem/mem_store.sv
hw/mem_int.sv
tb/mem_int_tb.sv

/* Makefile */
# Verilator lint and simulation of the memory-side interior

VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
LFLAGS    = --lint-only --timing
TOP       = mem_int_tb
FILELIST  = sim.f
OBJ_DIR   = obj_dir
PASS_MSG  = ** PASS **

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
